//--- sources.f
rs_pkg.sv
rs_dispatch_port.sv
rs_entry.sv
rs_issue_select.sv
rs.sv
rs_top.sv
tb_rs.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rs
FILELIST  = sources.f
LOG       = sim.log

SOURCES := $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_rs.sv
`timescale 1ns/1ps

module tb_rs import rs_pkg::*; ();

	localparam int rs_size    = 8;
	localparam int n_random   = 40;	// Random dispatches before back-pressure
	localparam int wait_limit = 400;	// Cycles allowed for any single wait

	logic                     clock;
	logic                     reset;
	logic                     dispatch_req;
	logic                     dispatch_ack;
	logic [tag_width-1:0]     dest_tag;
	logic [xlen-1:0]          opa;
	logic [xlen-1:0]          opb;
	logic                     opa_valid;
	logic                     opb_valid;
	logic [rob_idx_width-1:0] rob_idx;
	logic [31:0]              inst;
	logic                     cdb1_valid = 1'b0;
	logic [tag_width-1:0]     cdb1_tag = '0;
	logic [xlen-1:0]          cdb1_value = '0;
	logic                     cdb2_valid = 1'b0;
	logic [tag_width-1:0]     cdb2_tag = '0;
	logic [xlen-1:0]          cdb2_value = '0;
	logic                     adder_available = 1'b1;
	logic                     mult_available = 1'b1;
	logic                     memory_available = 1'b1;
	logic                     rs_full;
	logic                     issue_valid;
	logic [xlen-1:0]          issue_opa;
	logic [xlen-1:0]          issue_opb;
	logic [tag_width-1:0]     issue_dest_tag;
	logic [rob_idx_width-1:0] issue_rob_idx;
	logic [31:0]              issue_inst;
	logic [1:0]               issue_fu;

	integer seed = 32'h2a1b0d07;
	bit     checking = 1'b0;	// Monitor active once reset is released
	bit     hold_units = 1'b0;	// Force every unit unavailable
	int     value_errors = 0;	// Wrong issue fields
	int     protocol_errors = 0;	// Handshake and issue-once faults
	int     sequence_errors = 0;	// Main sequence checks
	int     issue_total = 0;
	int     next_rob = 0;
	int     next_tag = 0;

	// Reference model keyed by ROB index
	bit          dispatched [64];
	bit          issued [64];
	logic [63:0] exp_opa [64];	// Immediate value or junk when tagged
	logic [63:0] exp_opb [64];
	bit          opa_tagged [64];
	bit          opb_tagged [64];
	logic [6:0]  opa_tag [64];
	logic [6:0]  opb_tag [64];
	logic [6:0]  exp_dest [64];
	logic [31:0] exp_inst [64];

	// Tags armed by dispatch and sent by the CDB process
	bit          tag_armed [128];
	bit          tag_sent [128];
	logic [63:0] tag_value [128];

	bit          cur_a_tag;		// Current request still has tags to arm
	bit          cur_b_tag;
	logic [6:0]  cur_ta;
	logic [6:0]  cur_tb;
	bit          armed;

	bit          prev_ack = 1'b0;
	bit          prev_req = 1'b0;
	bit          prev_adder = 1'b0;
	bit          prev_mult = 1'b0;
	bit          prev_memory = 1'b0;

	rs_top #(.RS_SIZE(rs_size)) dut (.*);

	always #5 clock = ~clock;

	// Class from the opcode group and function code of the word
	function automatic logic [1:0] rule_class(input logic [31:0] w);
		logic [5:0] grp;
		grp = {w[31:29], 3'b000};
		if (grp == 6'h10 && w[11:5] == 7'h20) begin
			return 2'd1;	// Multiply
		end
		if (grp == 6'h08 || grp == 6'h20 || grp == 6'h28) begin
			return 2'd2;	// Memory
		end
		return 2'd0;
	endfunction

	task automatic abort(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic arm_current();
		if (cur_a_tag) tag_armed[cur_ta] = 1'b1;	// CDB may now send it
		if (cur_b_tag) tag_armed[cur_tb] = 1'b1;
		armed = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Four-phase dispatch
	////////////////////////////////////////////////////////////////////////////

	task automatic start_request(input bit all_tags);
		logic [31:0] w;
		logic [5:0]  r;
		logic [63:0] a;
		logic [63:0] b;
		logic [6:0]  d;
		bit          va;
		bit          vb;
		@(posedge clock);
		r = 6'(next_rob);
		next_rob++;
		w = $random(seed);
		case ($random(seed) & 3)
			0: begin
				w[31:29] = 3'b010;	// Operate group with MULQ
				w[11:5]  = 7'h20;
			end
			1: w[31:29] = 3'b101;	// Integer loads and stores
			default: ;
		endcase
		va = all_tags ? 1'b0 : (($random(seed) & 1) != 0);
		vb = all_tags ? 1'b0 : (($random(seed) & 1) != 0);
		a = {$random(seed), $random(seed)};
		b = {$random(seed), $random(seed)};
		d = 7'($random(seed));
		cur_a_tag = !va;
		cur_b_tag = !vb;
		if (!va) begin
			cur_ta = 7'(next_tag);
			next_tag++;
			a[6:0] = cur_ta;	// Upper bits left as junk
		end
		if (!vb) begin
			cur_tb = 7'(next_tag);
			next_tag++;
			b[6:0] = cur_tb;
		end
		exp_opa[r]    = a;
		exp_opb[r]    = b;
		opa_tagged[r] = !va;
		opb_tagged[r] = !vb;
		opa_tag[r]    = cur_ta;
		opb_tag[r]    = cur_tb;
		exp_dest[r]   = d;
		exp_inst[r]   = w;
		dispatched[r] = 1'b1;
		dispatch_req <= 1'b1;
		dest_tag     <= d;
		opa          <= a;
		opb          <= b;
		opa_valid    <= va;
		opb_valid    <= vb;
		rob_idx      <= r;
		inst         <= w;
		armed = 1'b0;
		@(negedge clock);
		// Not full now means the load lands next cycle where a CDB may hit it
		if (!rs_full) arm_current();
	endtask

	task automatic finish_request();
		int n;
		n = 0;
		while (!dispatch_ack) begin
			if (dut.load && !armed) arm_current();
			n++;
			if (n > wait_limit) abort("dispatch_ack to rise");
			@(negedge clock);
		end
		@(posedge clock);
		dispatch_req <= 1'b0;
		@(negedge clock);
		n = 0;
		while (dispatch_ack) begin
			n++;
			if (n > wait_limit) abort("dispatch_ack to fall");
			@(negedge clock);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (issue_total < next_rob) begin
			n++;
			if (n > wait_limit) abort("all dispatched instructions to issue");
			@(negedge clock);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// CDB broadcast and unit availability
	////////////////////////////////////////////////////////////////////////////

	task automatic pick_tag(output bit found, output logic [6:0] tag);
		int count;
		int k;
		count = 0;
		found = 1'b0;
		tag   = '0;
		for (int i = 0; i < 128; i++) begin
			if (tag_armed[i] && !tag_sent[i]) count++;
		end
		if (count == 0 || ($random(seed) & 3) == 0) return;	// Idle bus now and then
		k = int'($unsigned($random(seed)) % count);
		for (int i = 0; i < 128; i++) begin
			if (tag_armed[i] && !tag_sent[i]) begin
				if (k == 0 && !found) begin
					found = 1'b1;
					tag   = 7'(i);
					tag_sent[i]  = 1'b1;	// Second bus cannot pick it again
					tag_value[i] = {$random(seed), $random(seed)};
				end
				k--;
			end
		end
	endtask

	always @(posedge clock) begin
		bit         f1;
		bit         f2;
		logic [6:0] t1;
		logic [6:0] t2;
		if (reset) begin
			cdb1_valid <= 1'b0;
			cdb2_valid <= 1'b0;
		end else begin
			pick_tag(f1, t1);
			pick_tag(f2, t2);
			cdb1_valid <= f1;
			cdb1_tag   <= t1;
			cdb1_value <= tag_value[t1];
			cdb2_valid <= f2;
			cdb2_tag   <= t2;
			cdb2_value <= tag_value[t2];
		end
	end

	always @(posedge clock) begin
		if (hold_units) begin
			adder_available  <= 1'b0;
			mult_available   <= 1'b0;
			memory_available <= 1'b0;
		end else begin
			adder_available  <= ($random(seed) & 3) != 0;	// Mostly open
			mult_available   <= ($random(seed) & 3) != 0;
			memory_available <= ($random(seed) & 3) != 0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor at the falling edge where outputs are settled
	////////////////////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			value_errors++;
			$display("ERROR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_issue();
		logic [5:0]  r;
		logic [63:0] ea;
		logic [63:0] eb;
		logic [1:0]  ef;
		bit          open;
		r = issue_rob_idx;
		if (!dispatched[r] || issued[r]) begin
			protocol_errors++;
			$display("Issue for ROB index %h that is not in flight", r);
			return;
		end
		issued[r] = 1'b1;
		issue_total++;
		if ((opa_tagged[r] && !tag_sent[opa_tag[r]]) ||
		    (opb_tagged[r] && !tag_sent[opb_tag[r]])) begin
			value_errors++;
			$display("ROB index %h issued before its operand tag was broadcast", r);
		end
		ea = opa_tagged[r] ? tag_value[opa_tag[r]] : exp_opa[r];
		eb = opb_tagged[r] ? tag_value[opb_tag[r]] : exp_opb[r];
		ef = rule_class(exp_inst[r]);
		compare("issue_opa", ea, issue_opa);
		compare("issue_opb", eb, issue_opb);
		compare("issue_dest_tag", 64'(exp_dest[r]), 64'(issue_dest_tag));
		compare("issue_inst", 64'(exp_inst[r]), 64'(issue_inst));
		compare("issue_fu", 64'(ef), 64'(issue_fu));
		case (issue_fu)
			2'd0:    open = prev_adder;
			2'd1:    open = prev_mult;
			default: open = prev_memory;
		endcase
		if (!open) begin
			value_errors++;
			$display("Class %h issued while its unit was unavailable", issue_fu);
		end
	endtask

	always @(negedge clock) begin
		if (checking) begin
			if (dispatch_ack && !prev_ack && !dispatch_req) begin
				protocol_errors++;
				$display("dispatch_ack rose while dispatch_req was low");
			end
			if (prev_ack && !dispatch_ack && prev_req) begin
				protocol_errors++;
				$display("dispatch_ack fell before dispatch_req was released");
			end
			if (issue_valid) check_issue();
		end
		prev_ack    = dispatch_ack;
		prev_req    = dispatch_req;
		prev_adder  = adder_available;	// Selection cycle for next issue
		prev_mult   = mult_available;
		prev_memory = memory_available;
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int n;
		clock        = 1'b0;
		reset        = 1'b1;
		dispatch_req = 1'b0;
		dest_tag     = '0;
		opa          = '0;
		opb          = '0;
		opa_valid    = 1'b0;
		opb_valid    = 1'b0;
		rob_idx      = '0;
		inst         = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		repeat (3) begin
			@(negedge clock);
			if (dispatch_ack || issue_valid || rs_full) begin
				sequence_errors++;
				$display("ERROR after reset dispatch_ack %h issue_valid %h rs_full %h",
					dispatch_ack, issue_valid, rs_full);
			end
		end
		checking = 1'b1;

		repeat (n_random) begin
			start_request(1'b0);
			finish_request();
			repeat ($unsigned($random(seed)) % 4) @(posedge clock);
		end
		wait_drain();

		// Back-pressure with every unit closed
		@(negedge clock);
		hold_units = 1'b1;
		repeat (2) @(posedge clock);
		repeat (rs_size) begin
			start_request(1'b1);
			finish_request();
		end
		@(negedge clock);
		if (rs_full !== 1'b1) begin
			sequence_errors++;
			$display("ERROR rs_full expected %h actual %h", 1'b1, rs_full);
		end
		start_request(1'b1);
		for (n = 0; n < 20; n++) begin
			if (dispatch_ack) begin
				sequence_errors++;
				$display("Request acknowledged while the station was full");
			end
			@(negedge clock);
		end
		hold_units = 1'b0;
		finish_request();
		wait_drain();
		repeat (5) @(posedge clock);

		$display("Value errors %0d, protocol errors %0d, sequence errors %0d, issued %0d of %0d",
			value_errors, protocol_errors, sequence_errors, issue_total, next_rob);
		if (value_errors == 0 && protocol_errors == 0 && sequence_errors == 0 &&
		    issue_total == next_rob) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- rs_top.sv
`timescale 1ns/1ps

module rs_top import rs_pkg::*; #(
	parameter int RS_SIZE = 8
) (
	input  logic                     clock,
	input  logic                     reset,

	input  logic                     dispatch_req,
	output logic                     dispatch_ack,
	input  logic [tag_width-1:0]     dest_tag,	// Held stable by the source
	input  logic [xlen-1:0]          opa,
	input  logic [xlen-1:0]          opb,
	input  logic                     opa_valid,
	input  logic                     opb_valid,
	input  logic [rob_idx_width-1:0] rob_idx,
	input  inst_word_t               inst,

	input  logic                     cdb1_valid,
	input  logic [tag_width-1:0]     cdb1_tag,
	input  logic [xlen-1:0]          cdb1_value,
	input  logic                     cdb2_valid,
	input  logic [tag_width-1:0]     cdb2_tag,
	input  logic [xlen-1:0]          cdb2_value,

	input  logic                     adder_available,
	input  logic                     mult_available,
	input  logic                     memory_available,

	output logic                     rs_full,
	output logic                     issue_valid,
	output logic [xlen-1:0]          issue_opa,
	output logic [xlen-1:0]          issue_opb,
	output logic [tag_width-1:0]     issue_dest_tag,
	output logic [rob_idx_width-1:0] issue_rob_idx,
	output inst_word_t               issue_inst,
	output fu_class_t                issue_fu
);

	logic load;	// Dispatch port strobe into the station

	rs_dispatch_port u_dispatch_port (
		.clock        (clock),
		.reset        (reset),
		.dispatch_req (dispatch_req),
		.rs_full      (rs_full),
		.dispatch_ack (dispatch_ack),
		.load         (load)
	);

	rs #(
		.RS_SIZE (RS_SIZE)
	) u_rs (
		.clock            (clock),
		.reset            (reset),
		.load             (load),
		.dest_tag         (dest_tag),
		.opa              (opa),
		.opb              (opb),
		.opa_valid        (opa_valid),
		.opb_valid        (opb_valid),
		.rob_idx          (rob_idx),
		.inst             (inst),
		.cdb1_valid       (cdb1_valid),
		.cdb1_tag         (cdb1_tag),
		.cdb1_value       (cdb1_value),
		.cdb2_valid       (cdb2_valid),
		.cdb2_tag         (cdb2_tag),
		.cdb2_value       (cdb2_value),
		.adder_available  (adder_available),
		.mult_available   (mult_available),
		.memory_available (memory_available),
		.rs_full          (rs_full),
		.issue_valid      (issue_valid),
		.issue_opa        (issue_opa),
		.issue_opb        (issue_opb),
		.issue_dest_tag   (issue_dest_tag),
		.issue_rob_idx    (issue_rob_idx),
		.issue_inst       (issue_inst),
		.issue_fu         (issue_fu)
	);

endmodule

//--- rs.sv
`timescale 1ns/1ps

module rs import rs_pkg::*; #(
	parameter int RS_SIZE = 8
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     load,		// From the dispatch port
	input  logic [tag_width-1:0]     dest_tag,
	input  logic [xlen-1:0]          opa,
	input  logic [xlen-1:0]          opb,
	input  logic                     opa_valid,
	input  logic                     opb_valid,
	input  logic [rob_idx_width-1:0] rob_idx,
	input  inst_word_t               inst,

	input  logic                     cdb1_valid,
	input  logic [tag_width-1:0]     cdb1_tag,
	input  logic [xlen-1:0]          cdb1_value,
	input  logic                     cdb2_valid,
	input  logic [tag_width-1:0]     cdb2_tag,
	input  logic [xlen-1:0]          cdb2_value,

	input  logic                     adder_available,
	input  logic                     mult_available,
	input  logic                     memory_available,

	output logic                     rs_full,
	output logic                     issue_valid,
	output logic [xlen-1:0]          issue_opa,
	output logic [xlen-1:0]          issue_opb,
	output logic [tag_width-1:0]     issue_dest_tag,
	output logic [rob_idx_width-1:0] issue_rob_idx,
	output inst_word_t               issue_inst,
	output fu_class_t                issue_fu
);

	logic [RS_SIZE-1:0]                    busy;
	logic [RS_SIZE-1:0]                    ready;
	logic [RS_SIZE-1:0]                    load_entry;	// One-hot write enable
	logic [RS_SIZE-1:0]                    release_entries;
	fu_class_t [RS_SIZE-1:0]               entry_fu;
	logic [RS_SIZE-1:0][xlen-1:0]          entry_opa;
	logic [RS_SIZE-1:0][xlen-1:0]          entry_opb;
	logic [RS_SIZE-1:0][tag_width-1:0]     entry_dest_tag;
	logic [RS_SIZE-1:0][rob_idx_width-1:0] entry_rob_idx;
	inst_word_t [RS_SIZE-1:0]              entry_inst;

	fu_class_t  fu_dispatch;	// Class of the word being dispatched
	logic [5:0] op_group;
	logic [5:0] mem_group;
	logic       slot_found;

	////////////////////////////////////////////////////////////////////////////
	// Unit class decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		op_group  = {inst.op.opcode[5:3], 3'b000};
		mem_group = {inst.mem.opcode[5:3], 3'b000};
		if ((op_group == grp_operate) && (inst.op.func == op_mulq)) begin
			fu_dispatch = fu_mult;
		end else if ((mem_group == grp_mem_08) || (mem_group == grp_mem_20) ||
			     (mem_group == grp_mem_28)) begin
			fu_dispatch = fu_memory;
		end else begin
			fu_dispatch = fu_adder;	// Everything else goes to the ALU
		end
	end

	// Lowest free slot takes the dispatch
	always_comb begin
		slot_found = 1'b0;
		load_entry = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (!busy[i] && !slot_found) begin
				slot_found    = 1'b1;
				load_entry[i] = load;
			end
		end
	end

	assign rs_full = &busy;

	for (genvar i = 0; i < RS_SIZE; i++) begin : g_entry
		rs_entry u_entry (
			.clock         (clock),
			.reset         (reset),
			.load          (load_entry[i]),
			.release_entry (release_entries[i]),
			.dest_tag_in   (dest_tag),
			.opa_in        (opa),
			.opb_in        (opb),
			.opa_valid_in  (opa_valid),
			.opb_valid_in  (opb_valid),
			.rob_idx_in    (rob_idx),
			.inst_in       (inst),
			.fu_in         (fu_dispatch),
			.cdb1_valid    (cdb1_valid),
			.cdb1_tag      (cdb1_tag),
			.cdb1_value    (cdb1_value),
			.cdb2_valid    (cdb2_valid),
			.cdb2_tag      (cdb2_tag),
			.cdb2_value    (cdb2_value),
			.busy          (busy[i]),
			.ready         (ready[i]),
			.fu            (entry_fu[i]),
			.opa           (entry_opa[i]),
			.opb           (entry_opb[i]),
			.dest_tag      (entry_dest_tag[i]),
			.rob_idx       (entry_rob_idx[i]),
			.inst          (entry_inst[i])
		);
	end

	rs_issue_select #(
		.RS_SIZE (RS_SIZE)
	) u_issue_select (
		.clock            (clock),
		.reset            (reset),
		.ready            (ready),
		.entry_fu         (entry_fu),
		.adder_available  (adder_available),
		.mult_available   (mult_available),
		.memory_available (memory_available),
		.entry_opa        (entry_opa),
		.entry_opb        (entry_opb),
		.entry_dest_tag   (entry_dest_tag),
		.entry_rob_idx    (entry_rob_idx),
		.entry_inst       (entry_inst),
		.release_entries  (release_entries),
		.issue_valid      (issue_valid),
		.issue_opa        (issue_opa),
		.issue_opb        (issue_opb),
		.issue_dest_tag   (issue_dest_tag),
		.issue_rob_idx    (issue_rob_idx),
		.issue_inst       (issue_inst),
		.issue_fu         (issue_fu)
	);

endmodule

//--- rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select import rs_pkg::*; #(
	parameter int RS_SIZE = 8
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic [RS_SIZE-1:0]                    ready,
	input  fu_class_t [RS_SIZE-1:0]               entry_fu,
	input  logic                                  adder_available,
	input  logic                                  mult_available,
	input  logic                                  memory_available,

	input  logic [RS_SIZE-1:0][xlen-1:0]          entry_opa,
	input  logic [RS_SIZE-1:0][xlen-1:0]          entry_opb,
	input  logic [RS_SIZE-1:0][tag_width-1:0]     entry_dest_tag,
	input  logic [RS_SIZE-1:0][rob_idx_width-1:0] entry_rob_idx,
	input  inst_word_t [RS_SIZE-1:0]              entry_inst,

	output logic [RS_SIZE-1:0]                    release_entries,	// One-hot or zero
	output logic                                  issue_valid,
	output logic [xlen-1:0]                       issue_opa,
	output logic [xlen-1:0]                       issue_opb,
	output logic [tag_width-1:0]                  issue_dest_tag,
	output logic [rob_idx_width-1:0]              issue_rob_idx,
	output inst_word_t                            issue_inst,
	output fu_class_t                             issue_fu
);

	localparam int sel_width = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

	logic [RS_SIZE-1:0]   eligible;	// Ready and unit class open
	logic [sel_width-1:0] sel;
	logic                 found;

	always_comb begin
		for (int i = 0; i < RS_SIZE; i++) begin
			case (entry_fu[i])
				fu_adder:  eligible[i] = ready[i] && adder_available;
				fu_mult:   eligible[i] = ready[i] && mult_available;
				fu_memory: eligible[i] = ready[i] && memory_available;
				default:   eligible[i] = 1'b0;
			endcase
		end
	end

	// Lowest index wins without age ordering
	always_comb begin
		found           = 1'b0;
		sel             = '0;
		release_entries = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (eligible[i] && !found) begin
				found              = 1'b1;
				sel                = sel_width'(i);
				release_entries[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= found;	// Single-cycle pulse per pick
		end
	end

	always_ff @(posedge clock) begin
		if (found) begin
			issue_opa      <= entry_opa[sel];
			issue_opb      <= entry_opb[sel];
			issue_dest_tag <= entry_dest_tag[sel];
			issue_rob_idx  <= entry_rob_idx[sel];
			issue_inst     <= entry_inst[sel];
			issue_fu       <= entry_fu[sel];
		end
	end

	a_release_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(release_entries));

endmodule

//--- rs_entry.sv
`timescale 1ns/1ps

module rs_entry import rs_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     load,		// Write this entry
	input  logic                     release_entry,	// Issued, free it

	input  logic [tag_width-1:0]     dest_tag_in,
	input  logic [xlen-1:0]          opa_in,		// Value, or tag in low bits
	input  logic [xlen-1:0]          opb_in,
	input  logic                     opa_valid_in,	// Low means opa_in is a tag
	input  logic                     opb_valid_in,
	input  logic [rob_idx_width-1:0] rob_idx_in,
	input  inst_word_t               inst_in,
	input  fu_class_t                fu_in,		// Decoded by the station

	input  logic                     cdb1_valid,
	input  logic [tag_width-1:0]     cdb1_tag,
	input  logic [xlen-1:0]          cdb1_value,
	input  logic                     cdb2_valid,
	input  logic [tag_width-1:0]     cdb2_tag,
	input  logic [xlen-1:0]          cdb2_value,

	output logic                     busy,
	output logic                     ready,		// Both operands are values
	output fu_class_t                fu,
	output logic [xlen-1:0]          opa,
	output logic [xlen-1:0]          opb,
	output logic [tag_width-1:0]     dest_tag,
	output logic [rob_idx_width-1:0] rob_idx,
	output inst_word_t               inst
);

	logic            opa_ok;		// Stored opa is a value
	logic            opb_ok;
	logic [xlen-1:0] opa_src;		// Incoming on load, else stored
	logic [xlen-1:0] opb_src;
	logic            opa_ok_src;
	logic            opb_ok_src;
	logic            opa_hit1;
	logic            opa_hit2;
	logic            opb_hit1;
	logic            opb_hit2;
	logic [xlen-1:0] opa_next;
	logic [xlen-1:0] opb_next;
	logic            track;		// Operands live this cycle

	////////////////////////////////////////////////////////////////////////////
	// CDB wakeup, also on the load cycle
	////////////////////////////////////////////////////////////////////////////

	assign track      = load || busy;
	assign opa_src    = load ? opa_in : opa;
	assign opb_src    = load ? opb_in : opb;
	assign opa_ok_src = load ? opa_valid_in : opa_ok;
	assign opb_ok_src = load ? opb_valid_in : opb_ok;

	assign opa_hit1 = cdb1_valid && !opa_ok_src && (opa_src[tag_width-1:0] == cdb1_tag);
	assign opa_hit2 = cdb2_valid && !opa_ok_src && (opa_src[tag_width-1:0] == cdb2_tag);
	assign opb_hit1 = cdb1_valid && !opb_ok_src && (opb_src[tag_width-1:0] == cdb1_tag);
	assign opb_hit2 = cdb2_valid && !opb_ok_src && (opb_src[tag_width-1:0] == cdb2_tag);

	// Tags are unique across the two CDBs so at most one hit per operand
	assign opa_next = opa_hit1 ? cdb1_value : (opa_hit2 ? cdb2_value : opa_src);
	assign opb_next = opb_hit1 ? cdb1_value : (opb_hit2 ? cdb2_value : opb_src);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy   <= 1'b0;
			opa_ok <= 1'b0;
			opb_ok <= 1'b0;
		end else begin
			if (load) begin
				busy <= 1'b1;
			end else if (release_entry) begin
				busy <= 1'b0;	// Free at the issue edge
			end
			if (track) begin
				opa_ok <= opa_ok_src || opa_hit1 || opa_hit2;
				opb_ok <= opb_ok_src || opb_hit1 || opb_hit2;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (track) begin
			opa <= opa_next;
			opb <= opb_next;
		end
		if (load) begin
			dest_tag <= dest_tag_in;
			rob_idx  <= rob_idx_in;
			inst     <= inst_in;
			fu       <= fu_in;
		end
	end

	assign ready = busy && opa_ok && opb_ok;

	// Allocation only targets free entries
	a_load_free: assert property (@(posedge clock) disable iff (reset)
		load |-> !busy);

	// Picker releases only entries that are ready
	a_release_ready: assert property (@(posedge clock) disable iff (reset)
		release_entry |-> ready);

endmodule

//--- rs_dispatch_port.sv
`timescale 1ns/1ps

module rs_dispatch_port (
	input  logic clock,
	input  logic reset,
	input  logic dispatch_req,	// Four-phase request from rename
	input  logic rs_full,		// No free entry left
	output logic dispatch_ack,	// Held high until req drops
	output logic load		// One-cycle write strobe into the station
);

	localparam logic [1:0] st_idle = 2'd0;	// Waiting for a fresh request
	localparam logic [1:0] st_load = 2'd1;	// Request seen, waiting for a slot
	localparam logic [1:0] st_hold = 2'd2;	// Ack up, waiting for req low

	logic [1:0] state;
	logic [1:0] state_next;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (dispatch_req) begin	// Ack is low here by construction
					state_next = st_load;
				end
			end
			st_load: begin
				if (!rs_full) begin	// Write happens this cycle
					state_next = st_hold;
				end
			end
			st_hold: begin
				if (!dispatch_req) begin	// Return to zero phase
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	assign load         = (state == st_load) && !rs_full;	// Back-pressure stalls here
	assign dispatch_ack = (state == st_hold);

	// Station never written when it reports full
	a_no_load_when_full: assert property (@(posedge clock) disable iff (reset)
		load |-> !rs_full);

endmodule

//--- rs_pkg.sv
package rs_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////////////////////////////////////////

	localparam int xlen          = 64;	// Register and CDB value width
	localparam int tag_width     = 7;	// 128 physical registers
	localparam int rob_idx_width = 6;	// 64 reorder buffer slots

	////////////////////////////////////////////////////////////////////////////
	// Functional unit classes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		fu_adder  = 2'd0,	// Integer ops, compares, branches
		fu_mult   = 2'd1,	// 64-bit multiply only
		fu_memory = 2'd2	// Loads and stores
	} fu_class_t;

	// Opcode groups, upper three opcode bits with the low three cleared
	localparam logic [5:0] grp_operate = 6'h10;	// Integer operate group
	localparam logic [5:0] grp_mem_08  = 6'h08;	// Address calc and unaligned loads
	localparam logic [5:0] grp_mem_20  = 6'h20;	// FP loads and stores
	localparam logic [5:0] grp_mem_28  = 6'h28;	// Integer loads and stores

	localparam logic [6:0] op_mulq = 7'h20;	// Operate func code of MULQ

	////////////////////////////////////////////////////////////////////////////
	// Instruction word, memory and operate formats
	////////////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  ra;		// Data register
			logic [4:0]  rb;		// Base register
			logic [15:0] displacement;	// Signed byte offset
		} mem;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  ra;
			logic [4:0]  rb;
			logic [2:0]  sbz_lit;	// With rb forms the 8-bit literal
			logic        is_literal;	// Set when opb is the literal
			logic [6:0]  func;		// Operation within the group
			logic [4:0]  rc;		// Destination register
		} op;
	} inst_word_t;

endpackage
